// File: Bender.yml
package:
  name: fb_frame_buffer_ctrl

sources:
  - hw/fb_pkg.sv
  - hw/fb_event_sync.sv
  - hw/fb_write_channel.sv
  - hw/fb_bank_rotator.sv
  - hw/fb_read_channel.sv
  - hw/fb_frame_buffer_ctrl.sv
  - target: test
    files:
      - tests/tb_fb_frame_buffer_ctrl.sv

// File: fb_frame_buffer_ctrl.f
hw/fb_pkg.sv
hw/fb_event_sync.sv
hw/fb_write_channel.sv
hw/fb_bank_rotator.sv
hw/fb_read_channel.sv
hw/fb_frame_buffer_ctrl.sv
tests/tb_fb_frame_buffer_ctrl.sv

// File: hw/fb_bank_rotator.sv
`timescale 1ns/100ps

module fb_bank_rotator (
	input  logic          clk_133M,
	input  logic          rst_133,
	input  logic          vga_frame_edge_i,
	input  logic          frame_closed_i,
	output fb_pkg::bank_t spare_bank_o,
	output logic          rd_restart_o,
	output fb_pkg::bank_t rd_bank_o
);

	fb_pkg::bank_t cam_bank_q;    // being written
	fb_pkg::bank_t vga_bank_q;    // being displayed
	fb_pkg::bank_t spare_bank_q;  // last finished frame or free
	logic          fresh_q;       // spare holds an unshown frame
	logic          restart_q;

	always_ff @(posedge clk_133M or negedge rst_133) begin
		if (!rst_133) begin
			cam_bank_q   <= fb_pkg::RESET_CAM_BANK;
			vga_bank_q   <= fb_pkg::RESET_VGA_BANK;
			spare_bank_q <= fb_pkg::RESET_SPARE_BANK;
			fresh_q      <= 1'b0;
			restart_q    <= 1'b0;
		end else if (frame_closed_i) begin
			// camera moves on, finished frame parks in spare
			cam_bank_q   <= spare_bank_q;
			spare_bank_q <= cam_bank_q;
			fresh_q      <= 1'b1;
			restart_q    <= 1'b0;  // vga edge here is lost
		end else if (vga_frame_edge_i) begin
			restart_q <= 1'b1;
			if (fresh_q) begin
				// display picks up the newest frame
				vga_bank_q   <= spare_bank_q;
				spare_bank_q <= vga_bank_q;
				fresh_q      <= 1'b0;
			end
		end else begin
			restart_q <= 1'b0;
		end
	end

	assign spare_bank_o = spare_bank_q;
	assign rd_restart_o = restart_q;
	// display role already updated when restart is seen
	assign rd_bank_o    = vga_bank_q;

	// camera and display never share a bank, nor the spare
	a_roles_distinct: assert property (@(posedge clk_133M) disable iff (!rst_133)
		(cam_bank_q != vga_bank_q) && (cam_bank_q != spare_bank_q) &&
		(vga_bank_q != spare_bank_q))
		else $error("bank roles overlap");

endmodule

// File: hw/fb_event_sync.sv
`timescale 1ns/100ps

module fb_event_sync #(
	parameter int FIFO_USED_W = 11,
	parameter int WR_LEVEL    = 512,
	parameter int RD_LEVEL    = 1500
) (
	input  logic                   clk_133M,
	input  logic                   rst_133,
	input  logic                   cam_vsync_i,  // async to clk_133M
	input  logic                   vga_vsync_i,  // async to clk_133M
	input  logic [FIFO_USED_W-1:0] wr_used_i,
	input  logic [FIFO_USED_W-1:0] rd_used_i,
	output fb_pkg::frame_evt_t     evt_o
);

	// bit 1 = camera, bit 0 = vga
	logic [1:0] vs_meta_q;  // first sync flop
	logic [1:0] vs_sync_q;  // second sync flop
	logic [1:0] vs_prev_q;  // previous synced value
	logic [1:0] vs_edge_q;  // registered rising edge

	// bit 1 = write level, bit 0 = read level
	logic [1:0] lvl_raw;
	logic [1:0] lvl_d1_q;
	logic [1:0] lvl_d2_q;

	// write side wants a full burst, read side wants headroom
	assign lvl_raw[1] = (wr_used_i >= FIFO_USED_W'(WR_LEVEL));
	assign lvl_raw[0] = (rd_used_i <= FIFO_USED_W'(RD_LEVEL));

	always_ff @(posedge clk_133M or negedge rst_133) begin
		if (!rst_133) begin
			vs_meta_q <= '0;
			vs_sync_q <= '0;
			vs_prev_q <= '0;
			vs_edge_q <= '0;
		end else begin
			vs_meta_q <= {cam_vsync_i, vga_vsync_i};
			vs_sync_q <= vs_meta_q;
			vs_prev_q <= vs_sync_q;
			vs_edge_q <= vs_sync_q & ~vs_prev_q; // rise only, one cycle
		end
	end

	// fill counts cross from the fifo clocks, so two stages
	always_ff @(posedge clk_133M or negedge rst_133) begin
		if (!rst_133) begin
			lvl_d1_q <= '0;
			lvl_d2_q <= '0;
		end else begin
			lvl_d1_q <= lvl_raw;
			lvl_d2_q <= lvl_d1_q;
		end
	end

	assign evt_o = '{
		cam_frame_edge: vs_edge_q[1],
		vga_frame_edge: vs_edge_q[0],
		wr_level_ok:    lvl_d2_q[1],
		rd_level_low:   lvl_d2_q[0]
	};

endmodule

// File: hw/fb_frame_buffer_ctrl.sv
`timescale 1ns/100ps

module fb_frame_buffer_ctrl #(
	parameter int FIFO_USED_W = 11,
	parameter int WR_LEVEL    = 512,   // write fifo words for one burst
	parameter int RD_LEVEL    = 1500,  // read fifo depth is 2048
	parameter int MIN_ROWS    = 25
) (
	input  logic                   clk_133M,
	input  logic                   rst_133,
	input  logic                   cam_vsync_i,
	input  logic                   vga_vsync_i,
	input  logic [FIFO_USED_W-1:0] wr_used_i,
	input  logic [FIFO_USED_W-1:0] rd_used_i,
	// sdram controller write port
	output logic                   wr_req_o,
	input  logic                   wr_ack_i,
	output fb_pkg::sdram_addr_t    wr_addr_o,
	output logic                   wr_clear_o,
	output fb_pkg::row_t           wr_rows_o,
	// sdram controller read port
	output logic                   rd_req_o,
	input  logic                   rd_ack_i,
	output fb_pkg::sdram_addr_t    rd_addr_o,
	output logic                   rd_clear_o,
	output fb_pkg::row_t           rd_rows_o
);

	fb_pkg::frame_evt_t evt;
	logic               frame_closed;
	fb_pkg::bank_t      spare_bank;
	logic               rd_restart;
	fb_pkg::bank_t      rd_bank;

	fb_event_sync #(
		.FIFO_USED_W (FIFO_USED_W),
		.WR_LEVEL    (WR_LEVEL),
		.RD_LEVEL    (RD_LEVEL)
	) u_event_sync (
		.clk_133M    (clk_133M),
		.rst_133     (rst_133),
		.cam_vsync_i (cam_vsync_i),
		.vga_vsync_i (vga_vsync_i),
		.wr_used_i   (wr_used_i),
		.rd_used_i   (rd_used_i),
		.evt_o       (evt)
	);

	fb_write_channel #(
		.MIN_ROWS (MIN_ROWS)
	) u_write_channel (
		.clk_133M       (clk_133M),
		.rst_133        (rst_133),
		.evt_i          (evt),
		.wr_ack_i       (wr_ack_i),
		.spare_bank_i   (spare_bank),
		.wr_req_o       (wr_req_o),
		.wr_addr_o      (wr_addr_o),
		.wr_clear_o     (wr_clear_o),
		.frame_closed_o (frame_closed),
		.wr_rows_o      (wr_rows_o)
	);

	fb_bank_rotator u_bank_rotator (
		.clk_133M         (clk_133M),
		.rst_133          (rst_133),
		.vga_frame_edge_i (evt.vga_frame_edge),
		.frame_closed_i   (frame_closed),  // wins over a vga edge
		.spare_bank_o     (spare_bank),
		.rd_restart_o     (rd_restart),
		.rd_bank_o        (rd_bank)
	);

	fb_read_channel u_read_channel (
		.clk_133M       (clk_133M),
		.rst_133        (rst_133),
		.rd_level_low_i (evt.rd_level_low),
		.rd_ack_i       (rd_ack_i),
		.rd_restart_i   (rd_restart),
		.rd_bank_i      (rd_bank),
		.rd_req_o       (rd_req_o),
		.rd_addr_o      (rd_addr_o),
		.rd_clear_o     (rd_clear_o),
		.rd_rows_o      (rd_rows_o)
	);

endmodule

// File: hw/fb_pkg.sv
package fb_pkg;

	// sdram geometry as seen by the controller
	localparam int BANK_W = 2;
	localparam int ROW_W  = 13;
	localparam int COL_W  = 9;

	typedef logic [BANK_W-1:0] bank_t; // one of four sdram banks
	typedef logic [ROW_W-1:0]  row_t;  // row, doubles as burst count per frame

	// flat controller address {bank, row, col}
	typedef struct packed {
		bank_t            bank;
		row_t             row;
		logic [COL_W-1:0] col;  // always 0, one full-row burst per request
	} sdram_addr_t;

	// frame and fifo status from the sync stage
	typedef struct packed {
		logic cam_frame_edge; // pulse, camera vsync rise
		logic vga_frame_edge; // pulse, vga vsync rise
		logic wr_level_ok;    // level, write fifo holds a burst
		logic rd_level_low;   // level, read fifo has room
	} frame_evt_t;

	// bank roles after reset
	localparam bank_t RESET_CAM_BANK   = 2'd1;
	localparam bank_t RESET_VGA_BANK   = 2'd0;
	localparam bank_t RESET_SPARE_BANK = 2'd2;

	// the three roles only ever use banks 0..2, bank 3 stays free

endpackage

// File: hw/fb_read_channel.sv
`timescale 1ns/100ps

module fb_read_channel (
	input  logic                clk_133M,
	input  logic                rst_133,
	input  logic                rd_level_low_i,
	input  logic                rd_ack_i,
	input  logic                rd_restart_i,  // one per shown vga frame
	input  fb_pkg::bank_t       rd_bank_i,
	output logic                rd_req_o,
	output fb_pkg::sdram_addr_t rd_addr_o,
	output logic                rd_clear_o,
	output fb_pkg::row_t        rd_rows_o
);

	logic          rd_req_q;
	fb_pkg::bank_t rd_bank_q;
	fb_pkg::row_t  rd_row_q;
	logic          rd_clear_q;
	fb_pkg::row_t  rd_rows_q;  // rows read in last finished frame

	always_ff @(posedge clk_133M or negedge rst_133) begin
		if (!rst_133) begin
			rd_req_q   <= 1'b0;
			rd_bank_q  <= fb_pkg::RESET_VGA_BANK;
			rd_row_q   <= '0;
			rd_clear_q <= 1'b0;
			rd_rows_q  <= '0;
		end else if (rd_restart_i) begin
			// rewind to top of the chosen frame
			rd_row_q   <= '0;
			rd_bank_q  <= rd_bank_i;
			rd_req_q   <= 1'b0;
			rd_clear_q <= 1'b1;  // stale pixels flushed
			rd_rows_q  <= rd_row_q;
		end else begin
			rd_clear_q <= 1'b0;
			if (!rd_req_q) begin
				if (rd_level_low_i) begin
					rd_req_q <= 1'b1;
				end
			end else if (rd_ack_i) begin
				rd_row_q <= rd_row_q + fb_pkg::row_t'(1);
				rd_req_q <= 1'b0;
			end
		end
	end

	assign rd_req_o   = rd_req_q;
	assign rd_clear_o = rd_clear_q;
	assign rd_rows_o  = rd_rows_q;
	assign rd_addr_o  = '{bank: rd_bank_q, row: rd_row_q, col: '0};

	// request held across controller latency
	a_rd_req_held: assert property (@(posedge clk_133M) disable iff (!rst_133)
		rd_req_q && !rd_ack_i && !rd_restart_i |=> rd_req_q)
		else $error("read request dropped without ack or restart");

endmodule

// File: hw/fb_write_channel.sv
`timescale 1ns/100ps

module fb_write_channel #(
	parameter int MIN_ROWS = 25
) (
	input  logic                clk_133M,
	input  logic                rst_133,
	input  fb_pkg::frame_evt_t  evt_i,
	input  logic                wr_ack_i,
	input  fb_pkg::bank_t       spare_bank_i,  // next camera bank
	output logic                wr_req_o,
	output fb_pkg::sdram_addr_t wr_addr_o,
	output logic                wr_clear_o,
	output logic                frame_closed_o,
	output fb_pkg::row_t        wr_rows_o
);

	logic          wr_req_q;
	fb_pkg::bank_t wr_bank_q;
	fb_pkg::row_t  wr_row_q;    // next row to burst, also rows done
	logic          wr_clear_q;
	logic          closed_q;
	fb_pkg::row_t  wr_rows_q;   // rows of last closed frame
	logic          close_frame;

	// short frames are treated as noise from a restarting camera
	assign close_frame = evt_i.cam_frame_edge &&
		(wr_row_q >= fb_pkg::row_t'(MIN_ROWS));

	always_ff @(posedge clk_133M or negedge rst_133) begin
		if (!rst_133) begin
			wr_req_q   <= 1'b0;
			wr_bank_q  <= fb_pkg::RESET_CAM_BANK;
			wr_row_q   <= '0;
			wr_clear_q <= 1'b0;
			closed_q   <= 1'b0;
			wr_rows_q  <= '0;
		end else if (close_frame) begin
			wr_row_q   <= '0;
			wr_bank_q  <= spare_bank_i;  // spare becomes camera bank
			wr_req_q   <= 1'b0;          // outstanding burst abandoned
			wr_clear_q <= 1'b1;
			closed_q   <= 1'b1;
			wr_rows_q  <= wr_row_q;
		end else begin
			wr_clear_q <= 1'b0;
			closed_q   <= 1'b0;
			if (!wr_req_q) begin
				if (evt_i.wr_level_ok) begin
					wr_req_q <= 1'b1;  // address already stable here
				end
			end else if (wr_ack_i) begin
				wr_row_q <= wr_row_q + fb_pkg::row_t'(1);  // one row per burst
				wr_req_q <= 1'b0;  // low for at least a cycle
			end
		end
	end

	assign wr_req_o       = wr_req_q;
	assign wr_clear_o     = wr_clear_q;
	assign frame_closed_o = closed_q;
	assign wr_rows_o      = wr_rows_q;

	// full-row bursts, column stays at zero
	assign wr_addr_o = '{bank: wr_bank_q, row: wr_row_q, col: '0};

	// request is held through controller latency
	a_wr_req_held: assert property (@(posedge clk_133M) disable iff (!rst_133)
		wr_req_q && !wr_ack_i && !close_frame |=> wr_req_q)
		else $error("write request dropped without ack or close");

endmodule

// File: tests/tb_fb_frame_buffer_ctrl.sv
`timescale 1ns/100ps

module tb_fb_frame_buffer_ctrl;

	localparam int FIFO_USED_W = 11;
	localparam int WR_LEVEL    = 512;
	localparam int RD_LEVEL    = 1500;
	localparam int MIN_ROWS    = 25;
	localparam int CLK_PERIOD  = 8;
	localparam int N_STEPS     = 13;
	localparam int REQ_WAIT    = 20;  // cycles a request may take to rise
	localparam int PULSE_WIN   = 14;  // vsync in, clear out, roles settled

	// one row of the stimulus table
	typedef struct packed {
		logic [10:0] wr_used;
		logic [10:0] rd_used;
		logic [7:0]  wr_n;  // write bursts to acknowledge
		logic [7:0]  rd_n;  // read bursts to acknowledge
		logic        cam;   // camera vsync pulse after the bursts
		logic        vga;   // vga vsync pulse after that
	} step_t;

	logic                   clk_133M;
	logic                   rst_133;
	logic                   cam_vsync_i;
	logic                   vga_vsync_i;
	logic [FIFO_USED_W-1:0] wr_used_i;
	logic [FIFO_USED_W-1:0] rd_used_i;
	logic                   wr_req_o;
	logic                   wr_ack_i;
	fb_pkg::sdram_addr_t    wr_addr_o;
	logic                   wr_clear_o;
	fb_pkg::row_t           wr_rows_o;
	logic                   rd_req_o;
	logic                   rd_ack_i;
	fb_pkg::sdram_addr_t    rd_addr_o;
	logic                   rd_clear_o;
	fb_pkg::row_t           rd_rows_o;

	int          mismatches;
	int          failures;
	logic [15:0] lfsr_q;
	// reference model state
	int m_cam;
	int m_vga;
	int m_spare;
	int m_wr_row;
	int m_rd_row;
	int m_wr_rows;
	int m_rd_rows;
	bit m_fresh;
	bit m_wr_pend;  // write request expected high when settled
	bit m_rd_pend;

	fb_frame_buffer_ctrl #(
		.FIFO_USED_W (FIFO_USED_W),
		.WR_LEVEL    (WR_LEVEL),
		.RD_LEVEL    (RD_LEVEL),
		.MIN_ROWS    (MIN_ROWS)
	) DUT (
		.clk_133M    (clk_133M),
		.rst_133     (rst_133),
		.cam_vsync_i (cam_vsync_i),
		.vga_vsync_i (vga_vsync_i),
		.wr_used_i   (wr_used_i),
		.rd_used_i   (rd_used_i),
		.wr_req_o    (wr_req_o),
		.wr_ack_i    (wr_ack_i),
		.wr_addr_o   (wr_addr_o),
		.wr_clear_o  (wr_clear_o),
		.wr_rows_o   (wr_rows_o),
		.rd_req_o    (rd_req_o),
		.rd_ack_i    (rd_ack_i),
		.rd_addr_o   (rd_addr_o),
		.rd_clear_o  (rd_clear_o),
		.rd_rows_o   (rd_rows_o)
	);

	initial begin
		clk_133M = 1'b0;
		forever #(CLK_PERIOD / 2) clk_133M = ~clk_133M;
	end

	// wr_used, rd_used, wr bursts, rd bursts, cam, vga
	function automatic step_t step_at(input int i);
		case (i)
			0:  step_at = {11'd0,   11'd2000, 8'd0,  8'd0, 1'b0, 1'b0};  // idle after reset
			1:  step_at = {11'd600, 11'd2000, 8'd10, 8'd0, 1'b0, 1'b0};
			2:  step_at = {11'd600, 11'd2000, 8'd5,  8'd0, 1'b1, 1'b0};  // 15 rows, too short
			3:  step_at = {11'd600, 11'd1000, 8'd12, 8'd6, 1'b0, 1'b0};
			4:  step_at = {11'd100, 11'd1000, 8'd0,  8'd2, 1'b1, 1'b0};  // close at 27
			5:  step_at = {11'd600, 11'd1000, 8'd0,  8'd0, 1'b0, 1'b1};  // display takes it
			6:  step_at = {11'd600, 11'd1000, 8'd0,  8'd3, 1'b0, 1'b1};  // nothing new
			7:  step_at = {11'd600, 11'd1700, 8'd26, 8'd0, 1'b1, 1'b0};  // read fifo full
			8:  step_at = {11'd600, 11'd1700, 8'd0,  8'd1, 1'b0, 1'b1};
			9:  step_at = {11'd600, 11'd500,  8'd30, 8'd8, 1'b1, 1'b1};
			10: step_at = {11'd0,   11'd500,  8'd0,  8'd4, 1'b0, 1'b1};
			11: step_at = {11'd600, 11'd500,  8'd25, 8'd0, 1'b1, 1'b0};  // exactly min rows
			12: step_at = {11'd0,   11'd2047, 8'd0,  8'd1, 1'b0, 1'b1};
			default: step_at = '0;
		endcase
	endfunction

	// worst case per burst is a full request wait plus max ack delay
	function automatic int step_cycles(input step_t s);
		return 6 + (int'(s.wr_n) + int'(s.rd_n)) * (REQ_WAIT + 6) + 2 * PULSE_WIN;
	endfunction

	function automatic logic next_bit();
		logic b;
		b = lfsr_q[0];
		lfsr_q = lfsr_q >> 1;
		if (b) begin
			lfsr_q = lfsr_q ^ 16'hB400;  // galois taps 16,14,13,11
		end
		return b;
	endfunction

	task automatic compare(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			$display("mismatch at %0t: %s got %0h expected %0h", $time, name, got, exp);
			mismatches++;
		end
	endtask

	task automatic report_failure(input string what);
		$display("error at %0t: %s", $time, what);
		failures++;
	endtask

	// wait for each request, ack it after 1..4 cycles
	task automatic serve_bursts(input bit rd, input int step, input int n);
		fb_pkg::sdram_addr_t a;
		int delay;
		int t;
		for (int k = 0; k < n; k++) begin
			t = 0;
			while ((rd ? rd_req_o : wr_req_o) !== 1'b1 && t < REQ_WAIT) begin
				@(negedge clk_133M);
				t++;
			end
			if ((rd ? rd_req_o : wr_req_o) !== 1'b1) begin
				report_failure($sformatf("%s request never rose in step %0d",
					rd ? "read" : "write", step));
				return;
			end
			a = rd ? rd_addr_o : wr_addr_o;
			compare(rd ? "rd_addr_o.bank" : "wr_addr_o.bank", a.bank, rd ? m_vga : m_cam);
			compare(rd ? "rd_addr_o.row" : "wr_addr_o.row", a.row, rd ? m_rd_row : m_wr_row);
			delay = 1 + 2 * next_bit();
			delay = delay + next_bit();
			repeat (delay) @(negedge clk_133M);  // controller latency
			if (rd) rd_ack_i = 1'b1;
			else wr_ack_i = 1'b1;
			@(negedge clk_133M);
			rd_ack_i = 1'b0;
			wr_ack_i = 1'b0;
			if (rd) m_rd_row++;
			else m_wr_row++;
		end
	endtask

	// vsync high a few cycles, count clear pulses meanwhile
	task automatic vsync_window(input bit cam, input int exp_wr_clr, input int exp_rd_clr);
		int wc;
		int rc;
		wc = 0;
		rc = 0;
		if (cam) cam_vsync_i = 1'b1;
		else vga_vsync_i = 1'b1;
		for (int i = 0; i < PULSE_WIN; i++) begin
			@(negedge clk_133M);
			if (i == 3) begin
				cam_vsync_i = 1'b0;
				vga_vsync_i = 1'b0;
			end
			wc += int'(wr_clear_o === 1'b1);
			rc += int'(rd_clear_o === 1'b1);
		end
		compare("wr_clear_o pulses", wc, exp_wr_clr);
		compare("rd_clear_o pulses", rc, exp_rd_clr);
	endtask

	task automatic check_settled();
		compare("wr_addr_o.bank", wr_addr_o.bank, m_cam);
		compare("wr_addr_o.row", wr_addr_o.row, m_wr_row);
		compare("wr_addr_o.col", wr_addr_o.col, 0);
		compare("rd_addr_o.bank", rd_addr_o.bank, m_vga);
		compare("rd_addr_o.row", rd_addr_o.row, m_rd_row);
		compare("rd_addr_o.col", rd_addr_o.col, 0);
		compare("wr_rows_o", wr_rows_o, m_wr_rows);
		compare("rd_rows_o", rd_rows_o, m_rd_rows);
		compare("wr_req_o", wr_req_o, m_wr_pend);
		compare("rd_req_o", rd_req_o, m_rd_pend);
		compare("wr_clear_o", wr_clear_o, 0);
		compare("rd_clear_o", rd_clear_o, 0);
		compare("write bank differs from read bank", wr_addr_o.bank != rd_addr_o.bank, 1);
	endtask

	initial begin
		int worst;
		worst = 0;
		for (int i = 0; i < N_STEPS; i++) begin
			if (step_cycles(step_at(i)) > worst) worst = step_cycles(step_at(i));
		end
		#((N_STEPS * worst + 40) * CLK_PERIOD);
		$display("watchdog expired before the step table completed");
		$display("TESTBENCH FAILED");
		$finish;
	end

	initial begin
		step_t s;
		bit    wr_ok;
		bit    rd_ok;
		int    t;
		rst_133     = 1'b0;
		cam_vsync_i = 1'b0;
		vga_vsync_i = 1'b0;
		wr_used_i   = '0;
		rd_used_i   = 11'd2047;  // no room, keeps read side quiet
		wr_ack_i    = 1'b0;
		rd_ack_i    = 1'b0;
		mismatches  = 0;
		failures    = 0;
		lfsr_q      = 16'd84;
		m_cam       = 1;
		m_vga       = 0;
		m_spare     = 2;
		m_wr_row    = 0;
		m_rd_row    = 0;
		m_wr_rows   = 0;
		m_rd_rows   = 0;
		m_fresh     = 1'b0;
		m_wr_pend   = 1'b0;
		m_rd_pend   = 1'b0;
		repeat (10) @(negedge clk_133M);
		rst_133 = 1'b1;
		@(negedge clk_133M);
		check_settled();  // reset state

		for (int i = 0; i < N_STEPS; i++) begin
			s = step_at(i);
			wr_used_i = s.wr_used;
			rd_used_i = s.rd_used;
			repeat (4) @(negedge clk_133M);  // level flags through two stages
			wr_ok = (s.wr_used >= WR_LEVEL);
			rd_ok = (s.rd_used <= RD_LEVEL);
			serve_bursts(1'b0, i, s.wr_n);
			serve_bursts(1'b1, i, s.rd_n);
			if (s.wr_n > 0) m_wr_pend = 1'b0;
			if (s.rd_n > 0) m_rd_pend = 1'b0;
			if (s.cam) begin
				if (m_wr_row >= MIN_ROWS) begin
					m_wr_rows = m_wr_row;
					m_wr_row  = 0;
					t         = m_cam;  // camera takes the spare
					m_cam     = m_spare;
					m_spare   = t;
					m_fresh   = 1'b1;
					m_wr_pend = 1'b0;
					vsync_window(1'b1, 1, 0);
				end else begin
					vsync_window(1'b1, 0, 0);  // short frame ignored
				end
			end
			if (s.vga) begin
				m_rd_rows = m_rd_row;
				m_rd_row  = 0;
				m_rd_pend = 1'b0;
				if (m_fresh) begin
					t       = m_vga;
					m_vga   = m_spare;
					m_spare = t;
					m_fresh = 1'b0;
				end
				vsync_window(1'b0, 0, 1);
			end
			if (wr_ok) m_wr_pend = 1'b1;  // idle request rises again
			if (rd_ok) m_rd_pend = 1'b1;
			repeat (2) @(negedge clk_133M);
			check_settled();
		end

		$display("errors: %0d mismatches, %0d other failures", mismatches, failures);
		if (mismatches == 0 && failures == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule
